/* vlog.f */
logic/fetch_pkg.sv
logic/bpu_predecode.sv
logic/bpu_bht.sv
logic/fetch_stage.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
verif/fetch_clk_gen.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - logic/fetch_pkg.sv
  - logic/bpu_predecode.sv
  - logic/bpu_bht.sv
  - logic/fetch_stage.sv
  - logic/fetch_ctrl.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - verif/fetch_clk_gen.sv
      - verif/fetch_checker.sv
      - verif/fetch_tb.sv

/* verif/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

  import fetch_pkg::*;

  logic            clk;
  logic            rst_i;
  logic            imem_req_o;
  logic [XLEN-1:0] imem_addr_o;
  logic            imem_ack_i;
  logic [XLEN-1:0] imem_rdata_i;
  redirect_t       redirect_i;
  bpu_update_t     bpu_update_i;
  logic            if_valid_o;
  if_out_t         if_o;
  logic            id_ready_i;

  logic [15:0] lfsr_q = 16'd60;
  logic [31:0] prog [logic [31:0]];  // programmed words, NOP elsewhere
  logic [1:0]  bht_model [16];
  if_out_t     acc_q [$];            // accepted at decode since the last redirect
  logic [31:0] exp_pc = 32'h8000_0000;
  logic        bp_en = 1'b0;
  logic        delay_busy = 1'b0;
  logic [3:0]  delay_left;
  int          errors = 0;
  int          checks = 0;
  int          tests_failed = 0;

  fetch_clk_gen clk_gen_i (.clk_o(clk), .rst_o(rst_i));

  fetch_top fetch_top_i (
    .clk          (clk),
    .rst_i        (rst_i),
    .imem_req_o   (imem_req_o),
    .imem_addr_o  (imem_addr_o),
    .imem_ack_i   (imem_ack_i),
    .imem_rdata_i (imem_rdata_i),
    .redirect_i   (redirect_i),
    .bpu_update_i (bpu_update_i),
    .if_valid_o   (if_valid_o),
    .if_o         (if_o),
    .id_ready_i   (id_ready_i)
  );

  // galois lfsr, one step per bit taken
  function automatic logic [3:0] rand_bits(input int n);
    logic [3:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[2:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return prog.exists(addr) ? prog[addr] : 32'h0000_0013;
  endfunction

  // memory holds req for at least one more cycle
  function automatic logic slow_fetch_pending();
    return imem_req_o && !imem_ack_i && delay_busy && (delay_left != 4'd0);
  endfunction

  // expected address of the fetch after pc
  function automatic logic [31:0] predict_next(input logic [31:0] pc, input logic [31:0] w,
                                               input logic [1:0] cnt);
    logic [31:0] j_off;
    logic [31:0] b_off;
    j_off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    b_off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    if (pc[1:0] != 2'b00) return pc + 32'd4;  // trapped fetch, no prediction
    if (w[6:0] == 7'h6f) return pc + j_off;
    if (w[6:0] == 7'h63 && cnt >= 2'd2) return pc + b_off;
    return pc + 32'd4;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // memory slave with 0 to 3 cycles of latency, plus decode ready
  always @(posedge clk) begin
    #2;
    if (rst_i) begin
      imem_ack_i = 1'b0;
      delay_busy = 1'b0;
    end else if (imem_ack_i) begin
      if (!imem_req_o) begin
        imem_ack_i = 1'b0;  // phase 4
      end
    end else if (imem_req_o) begin
      if (!delay_busy) begin
        delay_left = rand_bits(2);
        delay_busy = 1'b1;
      end
      if (delay_left == 0) begin
        imem_ack_i   = 1'b1;
        imem_rdata_i = mem_word(imem_addr_o);
        delay_busy   = 1'b0;
      end else begin
        delay_left = delay_left - 4'd1;
      end
    end
    id_ready_i = bp_en ? (rand_bits(1) != 0) : 1'b1;
  end

  // compare process, mid-cycle where outputs are settled
  always @(negedge clk) begin
    logic [TRAP_LEN-1:0] exp_trap;
    logic [31:0]         exp_inst;
    exp_trap = '0;
    if (rst_i === 1'b0 && redirect_i.valid) begin
      exp_pc = redirect_i.pc;  // decode gets flushed too
      acc_q.delete();
    end else if (rst_i === 1'b0 && if_valid_o && id_ready_i) begin
      exp_trap[0] = (exp_pc[1:0] != 2'b00);
      exp_inst    = mem_word(exp_pc);
      check_value("if_o.pc", if_o.pc, exp_pc);
      check_value("if_o.inst", if_o.inst, exp_inst);
      check_value("if_o.trap", if_o.trap, exp_trap);
      acc_q.push_back(if_o);
      exp_pc = predict_next(exp_pc, exp_inst, bht_model[exp_pc[5:2]]);
    end
  end

  task automatic pop_accepted(output if_out_t item);
    int n;
    n = 0;
    while (acc_q.size() == 0 && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (acc_q.size() == 0) begin
      $display("timeout, no instruction reached decode within 200 cycles");
      errors++;
      item = '0;
    end else begin
      item = acc_q.pop_front();
    end
  endtask

  task automatic send_redirect(input logic [31:0] pc);
    @(posedge clk);
    #2;
    redirect_i = {1'b1, pc};
    @(posedge clk);
    #2;
    redirect_i = '0;
  endtask

  task automatic send_update(input logic [31:0] pc, input logic taken);
    int idx;
    idx = pc[5:2];
    @(posedge clk);
    #2;
    bpu_update_i = {1'b1, pc, taken, 1'b1};
    if (taken && bht_model[idx] != 2'd3) begin
      bht_model[idx]++;
    end else if (!taken && bht_model[idx] != 2'd0) begin
      bht_model[idx]--;
    end
    @(posedge clk);
    #2;
    bpu_update_i = '0;
  endtask

  // jump to the branch and look at what follows it
  task automatic branch_pass(input logic [31:0] exp_next);
    if_out_t item;
    send_redirect(32'h8000_0040);
    pop_accepted(item);
    check_value("if_o.pc", item.pc, 32'h8000_0040);
    pop_accepted(item);
    check_value("if_o.pc", item.pc, exp_next);
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: %0d errors", num, name, errors - errs_before);
      tests_failed++;
    end
  endtask

  initial begin
    if_out_t item;
    int      n;
    int      errs;
    int      sva_fails;
    imem_ack_i   = 1'b0;
    imem_rdata_i = '0;
    redirect_i   = '0;
    bpu_update_i = '0;
    id_ready_i   = 1'b1;
    for (int i = 0; i < 16; i++) begin
      bht_model[i] = 2'd1;  // weakly not taken
    end
    prog[32'h8000_0010] = 32'h1000_006f;  // jal x0, +0x100
    prog[32'h8000_0040] = 32'h0200_0063;  // beq x0, x0, +0x20
    prog[32'h8000_0402] = 32'h1000_006f;  // jal behind a misaligned pc
    n = 0;
    while (rst_i !== 1'b0 && n < 10) begin
      @(posedge clk);
      n++;
    end
    if (rst_i !== 1'b0) begin
      $display("timeout, reset never released");
      errors++;
    end

    errs = errors;
    for (int i = 0; i < 4; i++) begin
      pop_accepted(item);
      check_value("if_o.pc", item.pc, 32'h8000_0000 + 4 * i);
    end
    report_test(1, "sequential fetch", errs);

    errs = errors;
    pop_accepted(item);
    check_value("if_o.pc", item.pc, 32'h8000_0010);
    pop_accepted(item);
    check_value("if_o.pc", item.pc, 32'h8000_0110);
    report_test(2, "jal target", errs);

    errs = errors;
    branch_pass(32'h8000_0044);
    send_update(32'h8000_0040, 1'b1);
    send_update(32'h8000_0040, 1'b1);
    branch_pass(32'h8000_0060);
    send_update(32'h8000_0040, 1'b0);
    send_update(32'h8000_0040, 1'b0);
    branch_pass(32'h8000_0044);
    report_test(3, "branch training", errs);

    errs = errors;
    n = 0;
    // redirect must land while req is still waiting for ack
    while (!slow_fetch_pending() && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!slow_fetch_pending()) begin
      $display("timeout, no outstanding fetch to redirect");
      errors++;
    end
    send_redirect(32'h8000_0300);
    pop_accepted(item);
    check_value("if_o.pc", item.pc, 32'h8000_0300);
    pop_accepted(item);
    check_value("if_o.pc", item.pc, 32'h8000_0304);
    report_test(4, "redirect in flight", errs);

    errs = errors;
    send_redirect(32'h8000_0402);
    pop_accepted(item);
    check_value("if_o.pc", item.pc, 32'h8000_0402);
    check_value("if_o.trap", item.trap, 32'h0000_0001);
    pop_accepted(item);
    check_value("if_o.pc", item.pc, 32'h8000_0406);  // jal ignored
    report_test(5, "misaligned target", errs);

    errs = errors;
    send_redirect(32'h8000_0600);
    @(negedge clk);
    bp_en = 1'b1;
    for (int i = 0; i < 16; i++) begin
      pop_accepted(item);
      check_value("if_o.pc", item.pc, 32'h8000_0600 + 4 * i);
    end
    @(negedge clk);
    bp_en = 1'b0;
    report_test(6, "back-pressure", errs);

    sva_fails = fetch_top_i.fetch_ctrl_i.fetch_checker_i.fail_cnt;
    $display("summary: 6 tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_failed, checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verif/fetch_checker.sv */
`timescale 1ns/1ps

module fetch_checker (
  input logic                       clk,
  input logic                       rst_i,
  input logic                       req_i,
  input logic                       ack_i,
  input logic [fetch_pkg::XLEN-1:0] addr_i,
  input logic                       if_valid_i,
  input logic                       id_ready_i,
  input fetch_pkg::if_out_t         if_i
);

  int fail_cnt = 0;  // read by the testbench at the end

  // four-phase, req may only fall once ack is seen
  req_held: assert property (@(posedge clk) disable iff (rst_i)
    req_i && !ack_i |=> req_i)
    else begin
      $error("imem req fell before ack");
      fail_cnt++;
    end

  addr_stable: assert property (@(posedge clk) disable iff (rst_i)
    req_i && !ack_i |=> $stable(addr_i))
    else begin
      $error("imem addr changed while req was pending");
      fail_cnt++;
    end

  // decode stalled, payload must hold
  out_stable: assert property (@(posedge clk) disable iff (rst_i)
    if_valid_i && !id_ready_i |=> $stable(if_i))
    else begin
      $error("if_o changed under back-pressure");
      fail_cnt++;
    end

  req_in_reset: assert property (@(posedge clk) rst_i |=> !req_i)
    else begin
      $error("imem req high during reset");
      fail_cnt++;
    end

endmodule

bind fetch_ctrl fetch_checker fetch_checker_i (
  .clk        (clk),
  .rst_i      (rst_i),
  .req_i      (imem_req_o),
  .ack_i      (imem_ack_i),
  .addr_i     (imem_addr_o),
  .if_valid_i (if_valid_o),
  .id_ready_i (id_ready_i),
  .if_i       (if_o)
);

/* verif/fetch_clk_gen.sv */
`timescale 1ns/1ps

module fetch_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;  // 40 ns period
  end

  initial begin
    rst_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #2;
    rst_o = 1'b0;  // released just after the third edge
  end

endmodule

/* logic/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top (
  input  logic                       clk,
  input  logic                       rst_i,
  output logic                       imem_req_o,
  output logic [fetch_pkg::XLEN-1:0] imem_addr_o,
  input  logic                       imem_ack_i,
  input  logic [fetch_pkg::XLEN-1:0] imem_rdata_i,
  input  fetch_pkg::redirect_t       redirect_i,
  input  fetch_pkg::bpu_update_t     bpu_update_i,
  output logic                       if_valid_o,
  output fetch_pkg::if_out_t         if_o,
  input  logic                       id_ready_i
);

  import fetch_pkg::*;

  logic [XLEN-1:0] pc;
  logic            rdata_valid;
  if_out_t         stage;
  logic            stall;
  bpu_pred_t       pred;

  fetch_ctrl fetch_ctrl_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_ack_i    (imem_ack_i),
    .imem_rdata_i  (imem_rdata_i),
    .redirect_i    (redirect_i),
    .id_ready_i    (id_ready_i),
    .pred_i        (pred),
    .stage_i       (stage),
    .stall_i       (stall),
    .pc_o          (pc),
    .rdata_valid_o (rdata_valid),
    .if_valid_o    (if_valid_o),
    .if_o          (if_o)
  );

  // predictor lives inside the stage
  fetch_stage fetch_stage_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .pc_i          (pc),
    .rdata_valid_i (rdata_valid),
    .rdata_i       (imem_rdata_i),
    .bpu_update_i  (bpu_update_i),
    .stage_o       (stage),
    .stall_o       (stall),
    .pred_o        (pred)
  );

endmodule

/* logic/fetch_ctrl.sv */
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic                         clk,
  input  logic                         rst_i,
  output logic                         imem_req_o,
  output logic [fetch_pkg::XLEN-1:0]   imem_addr_o,
  input  logic                         imem_ack_i,
  input  logic [fetch_pkg::XLEN-1:0]   imem_rdata_i,
  input  fetch_pkg::redirect_t         redirect_i,
  input  logic                         id_ready_i,
  input  fetch_pkg::bpu_pred_t         pred_i,
  input  fetch_pkg::if_out_t           stage_i,
  input  logic                         stall_i,
  output logic [fetch_pkg::XLEN-1:0]   pc_o,
  output logic                         rdata_valid_o,
  output logic                         if_valid_o,
  output fetch_pkg::if_out_t           if_o
);

  import fetch_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT_ACK_LOW
  } state_e;

  state_e          state_q;
  logic [XLEN-1:0] pc_q;         // next address to fetch
  logic [XLEN-1:0] addr_q;       // address of the request on the bus
  logic            discard_q;    // reply in flight is stale
  logic            out_valid_q;
  if_out_t         out_q;
  logic            resp;
  logic            capture;
  logic            out_free;
  logic            issue;
  logic [XLEN-1:0] issue_pc;
  logic [XLEN-1:0] next_pc;

  assign resp     = (state_q == S_REQ) && imem_ack_i;
  assign capture  = !stall_i && !discard_q && !redirect_i.valid;
  // empty, draining this edge, or flushed by a redirect
  assign out_free = !out_valid_q || id_ready_i || redirect_i.valid;
  assign issue    = out_free && ((state_q == S_IDLE) ||
                                 ((state_q == S_WAIT_ACK_LOW) && !imem_ack_i));
  assign issue_pc = redirect_i.valid ? redirect_i.pc : pc_q;

  // redirect beats prediction beats fall-through
  assign next_pc = pred_i.valid ? (pred_i.op1 + pred_i.op2) : (addr_q + XLEN'(4));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= S_IDLE;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (issue) begin
            state_q <= S_REQ;
          end
        end
        S_REQ: begin
          if (imem_ack_i) begin
            state_q <= S_WAIT_ACK_LOW;  // drop req, wait for ack to fall
          end
        end
        S_WAIT_ACK_LOW: begin
          if (!imem_ack_i) begin
            state_q <= issue ? S_REQ : S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q <= issue_pc;  // held for the whole req phase
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q      <= RESET_PC;
      discard_q <= 1'b0;
    end else begin
      if (redirect_i.valid) begin
        pc_q <= redirect_i.pc;
      end else if (capture) begin
        pc_q <= next_pc;
      end
      if (redirect_i.valid && (state_q == S_REQ) && !imem_ack_i) begin
        discard_q <= 1'b1;
      end else if (resp) begin
        discard_q <= 1'b0;  // stale reply has come back
      end
    end
  end

  // decode-side output register
  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_valid_q <= 1'b0;
    end else if (redirect_i.valid) begin
      out_valid_q <= 1'b0;
    end else if (capture) begin
      out_valid_q <= 1'b1;
    end else if (id_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      out_q.pc   <= stage_i.pc;
      out_q.inst <= imem_rdata_i;  // word straight off the bus
      out_q.trap <= stage_i.trap;
    end
  end

  assign imem_req_o    = (state_q == S_REQ);
  assign imem_addr_o   = addr_q;
  assign pc_o          = addr_q;
  assign rdata_valid_o = resp;
  assign if_valid_o    = out_valid_q;
  assign if_o          = out_q;

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic [fetch_pkg::XLEN-1:0] pc_i,
  input  logic                       rdata_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,
  input  fetch_pkg::bpu_update_t     bpu_update_i,
  output fetch_pkg::if_out_t         stage_o,
  output logic                       stall_o,
  output fetch_pkg::bpu_pred_t       pred_o
);

  import fetch_pkg::*;

  logic                misaligned;
  logic [TRAP_LEN-1:0] trap;
  logic                is_jal;
  logic                is_branch;
  logic [XLEN-1:0]     op1;
  logic [XLEN-1:0]     op2;
  logic [1:0]          counter;

  assign stall_o    = !rdata_valid_i;  // memory has not answered yet
  assign misaligned = (pc_i[1:0] != 2'b00);

  // only the misaligned cause can fire here
  always_comb begin
    trap = '0;
    for (int i = 0; i < TRAP_LEN; i++) begin
      if (i == TRAP_INST_ADDR_MISALIGNED) begin
        trap[i] = misaligned;
      end else if (i == TRAP_INST_ACCESS_FAULT || i == TRAP_INST_PAGE_FAULT) begin
        trap[i] = 1'b0;  // no pmp or mmu in front of this memory
      end
    end
  end

  assign stage_o.pc   = pc_i;
  assign stage_o.inst = rdata_i;
  assign stage_o.trap = trap;

  bpu_predecode bpu_predecode_i (
    .inst_i      (inst_u'(rdata_i)),
    .pc_i        (pc_i),
    .is_jal_o    (is_jal),
    .is_branch_o (is_branch),
    .op1_o       (op1),
    .op2_o       (op2)
  );

  bpu_bht bpu_bht_i (
    .clk       (clk),
    .rst_i     (rst_i),
    .rd_pc_i   (pc_i),
    .counter_o (counter),
    .upd_i     (bpu_update_i)
  );

  // jal always taken, branch only when counter says so
  assign pred_o.valid = !misaligned && (is_jal || (is_branch && counter[1]));
  assign pred_o.op1   = op1;
  assign pred_o.op2   = op2;

endmodule

/* logic/bpu_bht.sv */
`timescale 1ns/1ps

module bpu_bht (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic [fetch_pkg::XLEN-1:0] rd_pc_i,
  output logic [1:0]                 counter_o,
  input  fetch_pkg::bpu_update_t     upd_i
);

  import fetch_pkg::*;

  logic [1:0]           cnt_q [BHT_ENTRIES];
  logic [BHT_IDX_W-1:0] rd_idx;
  logic [BHT_IDX_W-1:0] upd_idx;
  logic                 upd_en;

  // 2-bit saturating step
  function automatic logic [1:0] sat_step(input logic [1:0] cnt, input logic taken);
    logic [1:0] res;
    res = cnt;
    if (taken) begin
      if (cnt != 2'd3) begin
        res = cnt + 2'd1;
      end
    end else begin
      if (cnt != 2'd0) begin
        res = cnt - 2'd1;
      end
    end
    return res;
  endfunction

  // word index, bits 1:0 are always zero for aligned code
  assign rd_idx  = rd_pc_i[BHT_IDX_W+1:2];
  assign upd_idx = upd_i.pc[BHT_IDX_W+1:2];
  assign upd_en  = upd_i.valid && upd_i.is_branch;  // jal never trains

  assign counter_o = cnt_q[rd_idx];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        cnt_q[i] <= BHT_CNT_INIT;
      end
    end else if (upd_en) begin
      cnt_q[upd_idx] <= sat_step(cnt_q[upd_idx], upd_i.taken);
    end
  end

endmodule

/* logic/bpu_predecode.sv */
`timescale 1ns/1ps

module bpu_predecode (
  input  fetch_pkg::inst_u           inst_i,
  input  logic [fetch_pkg::XLEN-1:0] pc_i,
  output logic                       is_jal_o,
  output logic                       is_branch_o,
  output logic [fetch_pkg::XLEN-1:0] op1_o,
  output logic [fetch_pkg::XLEN-1:0] op2_o
);

  import fetch_pkg::*;

  logic [6:0]      opcode;
  logic [XLEN-1:0] j_imm;
  logic [XLEN-1:0] b_imm;

  // opcode sits in the same bits in both views
  assign opcode = inst_i.jtype.opcode;

  assign is_jal_o    = (opcode == OPC_JAL);
  assign is_branch_o = (opcode == OPC_BRANCH);

  // J immediate, 21 bits signed
  assign j_imm = {
    {11{inst_i.jtype.imm20}},
    inst_i.jtype.imm20,
    inst_i.jtype.imm19_12,
    inst_i.jtype.imm11,
    inst_i.jtype.imm10_1,
    1'b0
  };

  // B immediate, 13 bits signed
  assign b_imm = {
    {19{inst_i.btype.imm12}},
    inst_i.btype.imm12,
    inst_i.btype.imm11,
    inst_i.btype.imm10_5,
    inst_i.btype.imm4_1,
    1'b0
  };

  assign op1_o = pc_i;

  always_comb begin
    if (is_jal_o) begin
      op2_o = j_imm;
    end else if (is_branch_o) begin
      op2_o = b_imm;
    end else begin
      op2_o = XLEN'(4);  // plain fall-through
    end
  end

endmodule

/* logic/fetch_pkg.sv */
package fetch_pkg;

  localparam int XLEN     = 32;
  localparam int INST_LEN = 32;
  localparam int TRAP_LEN = 16;

  // trap bus bit positions, mcause numbering
  localparam int TRAP_INST_ADDR_MISALIGNED = 0;
  localparam int TRAP_INST_ACCESS_FAULT    = 1;
  localparam int TRAP_INST_PAGE_FAULT      = 12;

  localparam int BHT_IDX_W   = 4;
  localparam int BHT_ENTRIES = 1 << BHT_IDX_W;
  localparam logic [1:0] BHT_CNT_INIT = 2'd1;  // weakly not taken

  localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

  // J-type layout, msb first
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jtype_t;

  // B-type layout, msb first
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } btype_t;

  // one fetched word, two ways to read its immediate
  typedef union packed {
    jtype_t jtype;
    btype_t btype;
  } inst_u;

  // target = op1 + op2
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
  } bpu_pred_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic            taken;
    logic            is_branch;
  } bpu_update_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic [XLEN-1:0]     pc;
    logic [INST_LEN-1:0] inst;
    logic [TRAP_LEN-1:0] trap;
  } if_out_t;

endpackage
